// File: soc_pkg.sv
`default_nettype none

package soc_pkg;

    // master request, one strobe per transfer
    typedef struct packed {
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [7:0]  dat;
    } wb_req_t;

    // slave reply
    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } wb_rsp_t;

    // address seen as an I/O location
    typedef struct packed {
        logic [20:0] region;
        logic [2:0]  page;
        logic [7:0]  offset;
    } wb_io_addr_t;

    // address seen as a RAM location
    typedef struct packed {
        logic [21:0] upper;
        logic [9:0]  index;
    } wb_mem_addr_t;

    typedef union packed {
        wb_io_addr_t  io_view;
        wb_mem_addr_t mem_view;
    } wb_addr_u;

    // 0xfffff800 and up
    localparam logic [20:0] IO_REGION  = '1;
    localparam logic [2:0]  PAGE_TIMER = 3'd5;

    // timer register map
    localparam logic [1:0] TMR_RELOAD_LO = 2'd0;
    localparam logic [1:0] TMR_RELOAD_HI = 2'd1;
    localparam logic [1:0] TMR_CTRL      = 2'd2;
    localparam logic [1:0] TMR_STATUS    = 2'd3;

endpackage

`default_nettype wire

// File: wb8_decoder.sv
`default_nettype none

module wb8_decoder (
    input  soc_pkg::wb_req_t req_i,
    output logic             ram_stb_o,
    output logic             leds_stb_o,
    output logic             timer_stb_o,
    input  soc_pkg::wb_rsp_t ram_rsp_i,
    input  soc_pkg::wb_rsp_t leds_rsp_i,
    input  soc_pkg::wb_rsp_t timer_rsp_i,
    output soc_pkg::wb_rsp_t rsp_o
);
    import soc_pkg::*;

    wb_addr_u addr;

    assign addr = req_i.adr;

    always_comb begin
        ram_stb_o   = 1'b0;
        leds_stb_o  = 1'b0;
        timer_stb_o = 1'b0;
        rsp_o       = ram_rsp_i;

        // RAM takes everything below the top 2 KB of the memory view
        if (!(&addr.mem_view.upper[21:1])) begin
            ram_stb_o = req_i.stb;
        end

        // I/O pages come from the other view of the same word
        if (addr.io_view.region == IO_REGION) begin
            if (addr.io_view.page == PAGE_TIMER) begin
                timer_stb_o = req_i.stb;
                rsp_o       = timer_rsp_i;
            end else begin
                // every other I/O page lands on the LEDs
                leds_stb_o = req_i.stb;
                rsp_o      = leds_rsp_i;
            end
        end
    end

    // memory and I/O decodes must never claim the same address
    always_comb begin
        if (!$isunknown(req_i.stb)) begin
            assert ($onehot0({ram_stb_o, leds_stb_o, timer_stb_o}))
                else $error("decoder raised more than one slave strobe");
        end
    end

endmodule

`default_nettype wire

// File: ram_wb8.sv
`default_nettype none

module ram_wb8 #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  wire              clk,
    input  wire              rst_i,
    input  wire              stb_i,
    input  soc_pkg::wb_req_t req_i,
    output soc_pkg::wb_rsp_t rsp_o
);

    logic [7:0]               mem [2**RAM_ADDR_BITS];
    logic [7:0]               rd_q;
    logic                     ack_q;
    logic                     access;
    logic [RAM_ADDR_BITS-1:0] index;

    // address wraps modulo the depth
    assign index  = req_i.adr[RAM_ADDR_BITS-1:0];
    // one access per strobe, never back to back with an ack
    assign access = stb_i && !ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                mem[index] <= req_i.dat;
            end
            rd_q <= mem[index];
        end
    end

    assign rsp_o.dat = rd_q;
    assign rsp_o.ack = ack_q;

    ack_follows_stb: assert property (@(posedge clk) disable iff (rst_i)
        ack_q |-> $past(stb_i));

endmodule

`default_nettype wire

// File: leds_wb8.sv
`default_nettype none

module leds_wb8 (
    input  wire              clk,
    input  wire              rst_i,
    input  wire              stb_i,
    input  soc_pkg::wb_req_t req_i,
    output soc_pkg::wb_rsp_t rsp_o,
    output logic [7:0]       leds_o
);

    logic [7:0] leds_q;
    logic       ack_q;
    logic       access;

    assign access = stb_i && !ack_q;

    // offset is ignored, the whole page maps to one register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            leds_q <= 8'h00;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                leds_q <= req_i.dat;
            end
        end
    end

    assign leds_o    = leds_q;
    assign rsp_o.dat = leds_q;
    assign rsp_o.ack = ack_q;

    ack_follows_stb: assert property (@(posedge clk) disable iff (rst_i)
        ack_q |-> $past(stb_i));

endmodule

`default_nettype wire

// File: timer_wb8.sv
`default_nettype none

module timer_wb8 (
    input  wire              clk,
    input  wire              rst_i,
    input  wire              stb_i,
    input  soc_pkg::wb_req_t req_i,
    output soc_pkg::wb_rsp_t rsp_o,
    output logic             irq_o
);
    import soc_pkg::*;

    logic [15:0] reload_q;
    logic [15:0] count_q;
    logic        cnt_en_q;
    logic        irq_en_q;
    logic        flag_q;
    logic        ack_q;
    logic [7:0]  rd_q;
    logic        access;
    logic        wr;
    logic [1:0]  reg_sel;
    logic        expire;

    assign access  = stb_i && !ack_q;
    assign wr      = access && req_i.we;
    assign reg_sel = req_i.adr[1:0];
    // counter sits at zero for one clock, so a load of N gives N+1 clocks
    assign expire  = cnt_en_q && (count_q == 16'd0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q    <= 1'b0;
            reload_q <= 16'h0000;
            count_q  <= 16'h0000;
            cnt_en_q <= 1'b0;
            irq_en_q <= 1'b0;
            flag_q   <= 1'b0;
        end else begin
            ack_q <= access;

            // writing the high byte restarts the count
            if (wr && reg_sel == TMR_RELOAD_HI) begin
                count_q <= {req_i.dat, reload_q[7:0]};
            end else if (expire) begin
                count_q <= reload_q;
            end else if (cnt_en_q) begin
                count_q <= count_q - 16'd1;
            end

            // an expiry in the same cycle beats the clear
            if (expire) begin
                flag_q <= 1'b1;
            end else if (wr && reg_sel == TMR_STATUS && req_i.dat[0]) begin
                flag_q <= 1'b0;
            end

            if (wr) begin
                case (reg_sel)
                    TMR_RELOAD_LO: reload_q[7:0]  <= req_i.dat;
                    TMR_RELOAD_HI: reload_q[15:8] <= req_i.dat;
                    TMR_CTRL: begin
                        cnt_en_q <= req_i.dat[0];
                        irq_en_q <= req_i.dat[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    // read data captured on the edge that raises ack
    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_sel)
                TMR_RELOAD_LO: rd_q <= reload_q[7:0];
                TMR_RELOAD_HI: rd_q <= reload_q[15:8];
                TMR_CTRL:      rd_q <= {6'b0, irq_en_q, cnt_en_q};
                default:       rd_q <= {7'b0, flag_q};
            endcase
        end
    end

    assign rsp_o.dat = rd_q;
    assign rsp_o.ack = ack_q;
    assign irq_o     = flag_q && irq_en_q;

    irq_needs_enable: assert property (@(posedge clk) disable iff (rst_i)
        !irq_en_q |-> !irq_o);

endmodule

`default_nettype wire

// File: wb8_periph_top.sv
`default_nettype none

module wb8_periph_top #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  wire              clk,
    input  wire              rst_i,
    input  soc_pkg::wb_req_t bus_req_i,
    output soc_pkg::wb_rsp_t bus_rsp_o,
    output logic [7:0]       leds_o,
    output logic             irq_o
);
    import soc_pkg::*;

    logic    ram_stb;
    logic    leds_stb;
    logic    timer_stb;
    wb_rsp_t ram_rsp;
    wb_rsp_t leds_rsp;
    wb_rsp_t timer_rsp;

    // address decode and reply steering
    wb8_decoder u_decoder (
        .req_i       (bus_req_i),
        .ram_stb_o   (ram_stb),
        .leds_stb_o  (leds_stb),
        .timer_stb_o (timer_stb),
        .ram_rsp_i   (ram_rsp),
        .leds_rsp_i  (leds_rsp),
        .timer_rsp_i (timer_rsp),
        .rsp_o       (bus_rsp_o)
    );

    // all slaves see the same request, only the strobe differs
    ram_wb8 #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) u_ram (
        .clk   (clk),
        .rst_i (rst_i),
        .stb_i (ram_stb),
        .req_i (bus_req_i),
        .rsp_o (ram_rsp)
    );

    leds_wb8 u_leds (
        .clk    (clk),
        .rst_i  (rst_i),
        .stb_i  (leds_stb),
        .req_i  (bus_req_i),
        .rsp_o  (leds_rsp),
        .leds_o (leds_o)
    );

    timer_wb8 u_timer (
        .clk   (clk),
        .rst_i (rst_i),
        .stb_i (timer_stb),
        .req_i (bus_req_i),
        .rsp_o (timer_rsp),
        .irq_o (irq_o)
    );

endmodule

`default_nettype wire

// File: tb_wb8_periph_top.sv
`default_nettype none

module tb_wb8_periph_top;
    timeunit 1ns;
    timeprecision 100ps;
    import soc_pkg::*;

    localparam int RAM_ADDR_BITS = 10;
    localparam int ACK_LIMIT     = 16;
    localparam int POLL_LIMIT    = 40;
    localparam int RANDOM_COUNT  = 64;

    logic        clk;
    logic        rst_i;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;
    logic [7:0]  leds;
    logic        irq;
    logic [7:0]  vec_op[$];
    logic [31:0] vec_adr[$];
    logic [31:0] vec_dat[$];
    logic [31:0] vec_mask[$];
    logic [7:0]  model [2**RAM_ADDR_BITS];
    logic [31:0] lcg_state;
    int          watchdog_ns;
    int          checks;
    int          errors;
    int          test_errors;

    wb8_periph_top #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) DUT (
        .clk       (clk),
        .rst_i     (rst_i),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .leds_o    (leds),
        .irq_o     (irq)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        $display("[FAIL] %s expected %h got %h", name, expected, actual);
        errors++;
        test_errors++;
    endtask

    task automatic report_error(input string what);
        $display("error: %s", what);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input int num);
        $display("test %0d done: %0d errors", num, test_errors);
        test_errors = 0;
    endtask

    // entered and left 0.5 ns after a rising edge, stb held until ack
    task automatic transfer(input logic we, input logic [31:0] adr, input logic [7:0] wdat,
                            output logic [7:0] rdat, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        rdat = 8'h00;
        bus_req.stb = 1'b1;
        bus_req.we  = we;
        bus_req.adr = adr;
        bus_req.dat = wdat;
        while (!ok && waited < ACK_LIMIT) begin
            @(posedge clk);
            #0.5;
            waited++;
            if (bus_rsp.ack) begin
                ok = 1'b1;
                rdat = bus_rsp.dat;
            end
        end
        bus_req.stb = 1'b0;
        bus_req.we  = 1'b0;
        if (!ok) begin
            report_error($sformatf("no acknowledge from address %h", adr));
        end
    endtask

    task automatic poll_until(input logic [31:0] adr, input logic [7:0] expected,
                              input logic [7:0] mask);
        logic [7:0] rdat;
        logic       ok;
        logic       matched;
        int         tries;
        matched = 1'b0;
        ok = 1'b1;
        tries = 0;
        while (!matched && ok && tries < POLL_LIMIT) begin
            transfer(1'b0, adr, 8'h00, rdat, ok);
            tries++;
            matched = ok && ((rdat & mask) == (expected & mask));
        end
        checks++;
        if (ok && !matched) begin
            report_error($sformatf("address %h never reached %h under mask %h in %0d reads",
                                   adr, expected, mask, POLL_LIMIT));
        end
    endtask

    task automatic run_vector(input int i);
        logic [7:0] rdat;
        logic       ok;
        logic [7:0] d;
        logic [7:0] m;
        d = vec_dat[i][7:0];
        m = vec_mask[i][7:0];
        case (vec_op[i])
            "W": transfer(1'b1, vec_adr[i], d, rdat, ok);
            "R": begin
                transfer(1'b0, vec_adr[i], 8'h00, rdat, ok);
                if (ok) begin
                    checks++;
                    if ((rdat & m) != (d & m)) report_mismatch("bus_rsp_o.dat", d, rdat);
                end
            end
            "P": poll_until(vec_adr[i], d, m);
            "L": begin
                checks++;
                if ((leds & m) != (d & m)) report_mismatch("leds_o", d, leds);
            end
            "I": begin
                checks++;
                if (irq !== d[0]) report_mismatch("irq_o", {7'b0, d[0]}, {7'b0, irq});
            end
            "E": finish_test(int'(vec_adr[i]));
            default: report_error($sformatf("unknown operation in vector %0d", i));
        endcase
    endtask

    task automatic random_ram_test();
        logic [31:0] adrs [RANDOM_COUNT];
        logic [31:0] r;
        logic [7:0]  rdat;
        logic        ok;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            r = lcg_next();
            adrs[i] = {18'd0, r[13:0]};
            r = lcg_next();
            model[adrs[i][RAM_ADDR_BITS-1:0]] = r[23:16];
            transfer(1'b1, adrs[i], r[23:16], rdat, ok);
        end
        // read back through another alias of the same byte
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            transfer(1'b0, adrs[i] ^ (32'h5 << RAM_ADDR_BITS), 8'h00, rdat, ok);
            if (ok) begin
                checks++;
                if (rdat != model[adrs[i][RAM_ADDR_BITS-1:0]]) begin
                    report_mismatch("bus_rsp_o.dat", model[adrs[i][RAM_ADDR_BITS-1:0]], rdat);
                end
            end
        end
    endtask

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        string       line;
        string       rest;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] m;
        checks = 0;
        errors = 0;
        test_errors = 0;
        watchdog_ns = 0;
        lcg_state = 32'ha01e9ce3;
        rst_i = 1'b1;
        bus_req = '0;

        fd = $fopen("tb_input_vectors.txt", "r");
        if (fd == 0) begin
            report_error("could not open tb_input_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // skip blank lines and the column notes
                if (n > 1 && line.getc(0) != 8'h23) begin
                    rest = line.substr(1, line.len() - 1);
                    n = $sscanf(rest, "%h %h %h", a, d, m);
                    if (n == 3) begin
                        vec_op.push_back(line.getc(0));
                        vec_adr.push_back(a);
                        vec_dat.push_back(d);
                        vec_mask.push_back(m);
                    end else begin
                        report_error($sformatf("malformed vector line: %s", line));
                    end
                end
            end
            $fclose(fd);
        end
        watchdog_ns = (vec_op.size() + 2 * RANDOM_COUNT) * 200 + 100;

        repeat (2) @(posedge clk);
        #0.5;
        rst_i = 1'b0;
        checks += 3;
        if (leds !== 8'h00) report_mismatch("leds_o", 8'h00, leds);
        if (irq !== 1'b0) report_mismatch("irq_o", 8'h00, {7'b0, irq});
        if (bus_rsp.ack !== 1'b0) report_mismatch("bus_rsp_o.ack", 8'h00, {7'b0, bus_rsp.ack});
        finish_test(1);

        for (int i = 0; i < vec_op.size(); i++) begin
            run_vector(i);
        end
        random_ram_test();
        finish_test(5);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wb8_periph_top.f
soc_pkg.sv
wb8_decoder.sv
ram_wb8.sv
leds_wb8.sv
timer_wb8.sv
wb8_periph_top.sv
tb_wb8_periph_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line in the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_wb8_periph_top -f wb8_periph_top.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$log"; then
    exit 0
fi
exit 1

// File: tb_input_vectors.txt
# op address data mask, all hex; W write, R read and compare under mask, P poll a read
# until it matches under mask, L check leds_o, I check irq_o, E end of test number address
W 00000000 a5 ff
W 00000001 3c ff
W 000003ff 7e ff
R 00000000 a5 ff
R 00000001 3c ff
R 000003ff 7e ff
R 00000400 a5 ff
R 00000401 3c ff
R 000007ff 7e ff
E 00000002 00 00
W ffffff00 5a ff
L 00000000 5a ff
R ffffff00 5a ff
W fffff800 c3 ff
L 00000000 c3 ff
R ffffff10 c3 ff
E 00000003 00 00
W fffffd00 14 ff
W fffffd01 00 ff
W fffffd02 03 ff
P fffffd03 01 01
I 00000000 01 01
W fffffd02 02 ff
W fffffd03 01 ff
I 00000000 00 01
R fffffd03 00 01
W fffffd02 01 ff
P fffffd03 01 01
I 00000000 00 01
W fffffd02 00 ff
E 00000004 00 00
